/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_crtc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/crtc_checks.svh */
// CRT controller testbench checks

`ifndef CRTC_CHECKS_SVH
`define CRTC_CHECKS_SVH

// first error ends the run
task automatic stop_on_error(input string why);
	$display("%s", why);
	$display("SIMULATION FAILED");
	$fatal(1, "stopped after the first error");
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s = 8'h%02h, expected 8'h%02h",
			$time, name, got, exp));
endtask

task automatic check_adr(input string name, input logic [crtc_pkg::ADR_W-1:0] got,
	input logic [crtc_pkg::ADR_W-1:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s = 14'h%04h, expected 14'h%04h",
			$time, name, got, exp));
endtask

task automatic check_row(input string name, input logic [crtc_pkg::ROW_W-1:0] got,
	input logic [crtc_pkg::ROW_W-1:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s = %0d, expected %0d",
			$time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		stop_on_error($sformatf("** Error at %0t: %s = %b, expected %b",
			$time, name, got, exp));
endtask

// measured cycle counts
task automatic check_count(input string name, input int got, input int exp);
	if (got != exp)
		stop_on_error($sformatf("** Error at %0t: %s = %0d, expected %0d",
			$time, name, got, exp));
endtask

`endif

/* bench/tb_crtc.sv */
// CRT controller testbench

`timescale 1ns/1ps
`default_nettype none

module tb_crtc;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 4;
	localparam int RNG_SEED     = 32'h5e9b;
	// test timing
	localparam int HT    = 15;
	localparam int HD    = 10;
	localparam int HS    = 12;
	localparam int HP    = 3;
	localparam int VT    = 5;
	localparam int VF    = 2;
	localparam int VD    = 4;
	localparam int VS    = 5;
	localparam int VP    = 2;
	localparam int MS    = 3;
	localparam int CUR_S = 1;
	localparam int CUR_E = 2;
	localparam int FRAME_LINES  = (VT + 1) * (MS + 1) + VF;
	localparam int FRAME_CYCLES = FRAME_LINES * (HT + 1);
	// frames summed over all tests
	localparam int TEST_FRAMES  = 50;
	localparam int WATCHDOG_NS  = 2 * TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD;

	logic                       char_clk;
	logic                       nRESET;
	logic                       en;
	logic                       nCS;
	logic                       RnW;
	logic                       RS;
	logic                       LPSTB;
	logic [7:0]                 data_in;
	logic [7:0]                 data_out;
	logic                       data_oe;
	logic [crtc_pkg::ADR_W-1:0] framestore_adr;
	logic [crtc_pkg::ROW_W-1:0] scanline_row;
	logic                       display_en;
	logic                       h_sync;
	logic                       v_sync;
	logic                       cursor;

	// beam model state
	int                         mh;
	int                         msl;
	int                         mrow;
	bit                         madj;
	bit                         base_known;
	logic [crtc_pkg::ADR_W-1:0] mbase;
	logic [crtc_pkg::ADR_W-1:0] start_adr;
	logic [crtc_pkg::ADR_W-1:0] cur_adr;
	logic [1:0]                 blink;
	int                         seen_hits;
	int                         exp_hits;
	int                         frames_done;
	bit                         shown[$];

	`include "crtc_checks.svh"

	crtc_top u_dut (
		.char_clk       (char_clk),
		.nRESET         (nRESET),
		.en             (en),
		.nCS            (nCS),
		.RnW            (RnW),
		.RS             (RS),
		.LPSTB          (LPSTB),
		.data_in        (data_in),
		.data_out       (data_out),
		.data_oe        (data_oe),
		.framestore_adr (framestore_adr),
		.scanline_row   (scanline_row),
		.display_en     (display_en),
		.h_sync         (h_sync),
		.v_sync         (v_sync),
		.cursor         (cursor)
	);

	always #(CLK_PERIOD / 2) char_clk = ~char_clk;

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("watchdog expired before the tests finished");
	end

	task automatic bus_write(input logic rs, input logic [7:0] d);
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b1;
		nCS = 1'b0;
		RnW = 1'b0;
		RS = rs;
		data_in = d;
		@(negedge char_clk);
		check_bit("data_oe", data_oe, 1'b0);
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b0;
		nCS = 1'b1;
		RnW = 1'b1;
	endtask

	task automatic reg_write(input logic [crtc_pkg::SEL_W-1:0] sel, input logic [7:0] d);
		bus_write(1'b0, {3'b000, sel});
		bus_write(1'b1, d);
	endtask

	task automatic reg_read(input logic [crtc_pkg::SEL_W-1:0] sel, output logic [7:0] d);
		bus_write(1'b0, {3'b000, sel});
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b1;
		nCS = 1'b0;
		RnW = 1'b1;
		RS = 1'b1;
		@(negedge char_clk);
		check_bit("data_oe", data_oe, 1'b1);
		d = data_out;
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b0;
		nCS = 1'b1;
	endtask

	task automatic program_timing(input logic [13:0] start, input logic [13:0] cur,
		input logic [1:0] mode);
		reg_write(crtc_pkg::R_HTOTAL, 8'(HT));
		reg_write(crtc_pkg::R_HDISP, 8'(HD));
		reg_write(crtc_pkg::R_HSYNC, 8'(HS));
		reg_write(crtc_pkg::R_SYNCW, {4'(VP), 4'(HP)});
		reg_write(crtc_pkg::R_VTOTAL, 8'(VT));
		reg_write(crtc_pkg::R_VADJ, 8'(VF));
		reg_write(crtc_pkg::R_VDISP, 8'(VD));
		reg_write(crtc_pkg::R_VSYNC, 8'(VS));
		// ignored, no interlace
		reg_write(crtc_pkg::R_INTERLACE, 8'h03);
		reg_write(crtc_pkg::R_MAXSCAN, 8'(MS));
		reg_write(crtc_pkg::R_CUR_START, {1'b0, mode, 5'(CUR_S)});
		reg_write(crtc_pkg::R_CUR_END, 8'(CUR_E));
		reg_write(crtc_pkg::R_START_HI, {2'b00, start[13:8]});
		reg_write(crtc_pkg::R_START_LO, start[7:0]);
		reg_write(crtc_pkg::R_CUR_HI, {2'b00, cur[13:8]});
		reg_write(crtc_pkg::R_CUR_LO, cur[7:0]);
		start_adr = start;
		cur_adr = cur;
		blink = mode;
	endtask

	// somewhere inside the displayed area
	function automatic logic [13:0] pick_cursor(input logic [13:0] start);
		int row;
		int col;
		row = $urandom_range(VD - 1, 0);
		col = $urandom_range(HD - 1, 0);
		return start + 14'(row * HD + col);
	endfunction

	function automatic logic [13:0] model_adr();
		return mbase + 14'(mh);
	endfunction

	// compare outputs with the model at a negedge
	task automatic check_beam();
		int   line;
		logic den;
		logic hit;
		line = madj ? (VT + 1) * (MS + 1) + msl : mrow * (MS + 1) + msl;
		den = (mh < HD) && !madj && (mrow < VD);
		check_bit("h_sync", h_sync, (mh >= HS) && (mh < HS + HP));
		check_bit("v_sync", v_sync, (line >= VS * (MS + 1)) && (line < VS * (MS + 1) + VP));
		check_row("scanline_row", scanline_row, 5'(msl));
		check_bit("display_en", display_en, den);
		if (base_known) begin
			check_adr("framestore_adr", framestore_adr, model_adr());
			hit = den && (model_adr() == cur_adr) && (msl >= CUR_S) && (msl <= CUR_E);
			case (blink)
				crtc_pkg::BLINK_ON: check_bit("cursor", cursor, hit);
				crtc_pkg::BLINK_16: begin
					if (cursor)
						check_bit("cursor", cursor, hit);
					seen_hits += int'(cursor);
					exp_hits += int'(hit);
				end
				default: check_bit("cursor", cursor, 1'b0);
			endcase
		end
	endtask

	// one character clock of the beam
	task automatic advance_model();
		logic fend;
		if (mh != HT) begin
			mh++;
		end else begin
			mh = 0;
			fend = madj ? (msl == VF - 1) : (msl == MS && mrow == VT && VF == 0);
			if (fend) begin
				if (blink == crtc_pkg::BLINK_16 && base_known) begin
					if (exp_hits == 0)
						stop_on_error("cursor position never reached in a blink frame");
					if (seen_hits != 0 && seen_hits != exp_hits)
						stop_on_error("cursor shown only in part of a blink frame");
					shown.push_back(seen_hits != 0);
				end
				seen_hits = 0;
				exp_hits = 0;
				msl = 0;
				mrow = 0;
				madj = 1'b0;
				mbase = start_adr;
				base_known = 1'b1;
				frames_done++;
			end else if (!madj && msl == MS) begin
				msl = 0;
				mbase = mbase + 14'(HD);
				if (mrow == VT)
					madj = 1'b1;
				else
					mrow++;
			end else begin
				msl++;
			end
		end
	endtask

	task automatic step();
		check_beam();
		advance_model();
		@(negedge char_clk);
	endtask

	// v_sync rise marks count 0, scanline 0, row VS
	task automatic align_to_vsync();
		@(negedge char_clk);
		while (v_sync)
			@(negedge char_clk);
		while (!v_sync)
			@(negedge char_clk);
		mh = 0;
		msl = 0;
		mrow = VS;
		madj = 1'b0;
		base_known = 1'b0;
		seen_hits = 0;
		exp_hits = 0;
	endtask

	task automatic run_frames(input int n);
		int target;
		target = frames_done + n;
		while (frames_done < target)
			step();
	endtask

	task automatic measure_sync(input bit vert, input int exp_period, input int exp_width);
		int period;
		int width;
		period = 0;
		width = 0;
		@(negedge char_clk);
		while (vert ? v_sync : h_sync)
			@(negedge char_clk);
		while (!(vert ? v_sync : h_sync))
			@(negedge char_clk);
		while (vert ? v_sync : h_sync) begin
			width++;
			period++;
			@(negedge char_clk);
		end
		while (!(vert ? v_sync : h_sync)) begin
			period++;
			@(negedge char_clk);
		end
		check_count(vert ? "v_sync period" : "h_sync period", period, exp_period);
		check_count(vert ? "v_sync width" : "h_sync width", width, exp_width);
	endtask

	task automatic check_idle_outputs();
		check_bit("h_sync", h_sync, 1'b0);
		check_bit("v_sync", v_sync, 1'b0);
		check_bit("display_en", display_en, 1'b0);
		check_bit("cursor", cursor, 1'b0);
		check_bit("data_oe", data_oe, 1'b0);
		check_byte("data_out", data_out, 8'h00);
		check_adr("framestore_adr", framestore_adr, '0);
		check_row("scanline_row", scanline_row, '0);
	endtask

	task automatic reset_and_readback();
		logic [7:0] d;
		repeat (2) begin
			@(negedge char_clk);
			check_idle_outputs();
		end
		// high bits of the cursor byte are dropped
		reg_write(crtc_pkg::R_CUR_HI, 8'hea);
		reg_write(crtc_pkg::R_CUR_LO, 8'hc5);
		reg_write(crtc_pkg::R_HSYNC, 8'd12);
		reg_read(crtc_pkg::R_CUR_HI, d);
		check_byte("data_out", d, 8'h2a);
		reg_read(crtc_pkg::R_CUR_LO, d);
		check_byte("data_out", d, 8'hc5);
		reg_read(crtc_pkg::R_HSYNC, d);
		check_byte("data_out", d, 8'h00);
		@(posedge char_clk);
		#DRIVE_DLY;
		nCS = 1'b0;
		@(negedge char_clk);
		check_bit("data_oe", data_oe, 1'b0);
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b1;
		nCS = 1'b1;
		@(negedge char_clk);
		check_bit("data_oe", data_oe, 1'b0);
		@(posedge char_clk);
		#DRIVE_DLY;
		en = 1'b0;
	endtask

	task automatic horizontal_timing();
		program_timing('0, 14'd23, crtc_pkg::BLINK_OFF);
		align_to_vsync();
		run_frames(2);
		measure_sync(1'b0, HT + 1, HP);
	endtask

	task automatic vertical_timing();
		measure_sync(1'b1, FRAME_LINES * (HT + 1), VP * (HT + 1));
		align_to_vsync();
		run_frames(2);
	endtask

	task automatic framestore_addressing();
		logic [13:0] start;
		start = 14'($urandom);
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_ON);
		align_to_vsync();
		run_frames(2);
		// a frame near the top of memory wraps
		start = 14'h3fd8 + 14'($urandom_range(31, 0));
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_ON);
		align_to_vsync();
		run_frames(2);
	endtask

	task automatic cursor_blink_modes();
		logic [13:0] start;
		bit          ok;
		bit          found;
		start = 14'($urandom);
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_ON);
		align_to_vsync();
		run_frames(2);
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_OFF);
		align_to_vsync();
		run_frames(2);
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_16);
		shown.delete();
		align_to_vsync();
		run_frames(17);
		// eight frames on, eight off, at any phase
		found = 1'b0;
		for (int p = 0; p < 16; p++) begin
			ok = 1'b1;
			foreach (shown[f])
				if (shown[f] != (((f + p) & 8) == 0))
					ok = 1'b0;
			if (ok)
				found = 1'b1;
		end
		if (!found || shown.size() < 16)
			stop_on_error("cursor blink does not follow a 16 frame cycle");
	endtask

	task automatic light_pen_capture();
		logic [13:0] start;
		logic [13:0] lp_adr;
		logic [7:0]  d;
		bit          sent;
		start = 14'($urandom);
		program_timing(start, pick_cursor(start), crtc_pkg::BLINK_ON);
		sent = 1'b0;
		lp_adr = '0;
		align_to_vsync();
		while (!sent) begin
			check_beam();
			advance_model();
			// strobe is sampled at row 2, scanline 1, character 5
			if (base_known && mrow == 2 && msl == 1 && mh == 5) begin
				lp_adr = model_adr();
				@(posedge char_clk);
				#DRIVE_DLY;
				LPSTB = 1'b1;
				sent = 1'b1;
			end
			@(negedge char_clk);
		end
		repeat (3)
			step();
		@(posedge char_clk);
		#DRIVE_DLY;
		LPSTB = 1'b0;
		reg_read(crtc_pkg::R_LPEN_HI, d);
		check_byte("data_out", d, {2'b00, lp_adr[13:8]});
		reg_read(crtc_pkg::R_LPEN_LO, d);
		check_byte("data_out", d, lp_adr[7:0]);
	endtask

	initial begin
		void'($urandom(RNG_SEED));
		char_clk = 1'b0;
		nRESET = 1'b0;
		en = 1'b0;
		nCS = 1'b1;
		RnW = 1'b1;
		RS = 1'b0;
		LPSTB = 1'b0;
		data_in = 8'h00;
		mh = 0;
		msl = 0;
		mrow = 0;
		madj = 1'b0;
		base_known = 1'b0;
		mbase = '0;
		start_adr = '0;
		cur_adr = '0;
		blink = crtc_pkg::BLINK_OFF;
		seen_hits = 0;
		exp_hits = 0;
		frames_done = 0;
		repeat (RESET_CYCLES)
			@(posedge char_clk);
		#DRIVE_DLY;
		nRESET = 1'b1;
		reset_and_readback();
		horizontal_timing();
		vertical_timing();
		framestore_addressing();
		cursor_blink_modes();
		light_pen_capture();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/crtc_horiz.sv */
// CRT controller horizontal timing

`timescale 1ns/1ps
`default_nettype none

module crtc_horiz (
	input  logic       char_clk,
	input  logic       nRESET,
	output logic       h_sync,
	crtc_cfg_if.horiz  cfg,
	crtc_beam_if.horiz beam
);

	logic [crtc_pkg::HCNT_W-1:0]  h_count;
	logic [crtc_pkg::PULSE_W-1:0] pulse_left;
	logic                         sync_start;

	assign beam.h_count      = h_count;
	assign beam.scanline_end = (h_count == cfg.horz_total);
	assign beam.h_display    = (h_count < cfg.horz_display);

	// zero width means no pulse at all
	assign sync_start = (h_count == cfg.horz_syncpos) && (cfg.horz_pulse != '0);
	assign h_sync     = sync_start || (pulse_left != '0);

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			h_count <= '0;
		end else if (beam.scanline_end) begin
			h_count <= '0;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// characters still to go after the current one
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			pulse_left <= '0;
		end else if (sync_start) begin
			pulse_left <= cfg.horz_pulse - 1'b1;
		end else if (pulse_left != '0) begin
			pulse_left <= pulse_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/crtc_if.sv */
// CRT controller internal interfaces

`timescale 1ns/1ps
`default_nettype none

// timing register values, written only by the register block
interface crtc_cfg_if;
	logic [crtc_pkg::HCNT_W-1:0]  horz_total;
	logic [crtc_pkg::HCNT_W-1:0]  horz_display;
	logic [crtc_pkg::HCNT_W-1:0]  horz_syncpos;
	logic [crtc_pkg::PULSE_W-1:0] horz_pulse;
	logic [crtc_pkg::VCNT_W-1:0]  vert_total;
	logic [crtc_pkg::ROW_W-1:0]   vert_fraction;
	logic [crtc_pkg::VCNT_W-1:0]  vert_display;
	logic [crtc_pkg::VCNT_W-1:0]  vert_syncpos;
	logic [crtc_pkg::PULSE_W-1:0] vert_pulse;
	logic [crtc_pkg::ROW_W-1:0]   max_scanline;
	logic [crtc_pkg::ROW_W-1:0]   cursor_start_row;
	logic [crtc_pkg::ROW_W-1:0]   cursor_end_row;
	logic [1:0]                   cursor_blink_mode;
	logic [crtc_pkg::ADR_W-1:0]   start_address;
	logic [crtc_pkg::ADR_W-1:0]   cursor_adr;

	modport regs (
		output horz_total, horz_display, horz_syncpos, horz_pulse,
		output vert_total, vert_fraction, vert_display, vert_syncpos, vert_pulse,
		output max_scanline, cursor_start_row, cursor_end_row, cursor_blink_mode,
		output start_address, cursor_adr
	);
	modport horiz (input horz_total, horz_display, horz_syncpos, horz_pulse);
	modport vert (
		input vert_total, vert_fraction, vert_display, vert_syncpos, vert_pulse,
		input max_scanline
	);
	modport scan (
		input horz_display, cursor_start_row, cursor_end_row, cursor_blink_mode,
		input start_address, cursor_adr
	);
endinterface

// beam position shared between the counter blocks
interface crtc_beam_if;
	logic                        scanline_end;
	logic                        h_display;
	logic [crtc_pkg::HCNT_W-1:0] h_count;
	logic                        row_start;
	logic                        frame_end;
	logic                        v_display;
	logic [crtc_pkg::ROW_W-1:0]  scanline_row;
	logic [crtc_pkg::ADR_W-1:0]  framestore_adr;

	modport horiz (output scanline_end, h_display, h_count);
	modport vert (
		input scanline_end,
		output row_start, frame_end, v_display, scanline_row
	);
	modport scan (
		input h_display, h_count, row_start, frame_end, v_display, scanline_row,
		output framestore_adr
	);
	modport regs (input framestore_adr);
endinterface

`default_nettype wire

/* design/crtc_pkg.sv */
// CRT controller shared definitions

`default_nettype none

package crtc_pkg;

	// field widths
	localparam int ADR_W   = 14;
	localparam int ROW_W   = 5;
	localparam int HCNT_W  = 8;
	localparam int VCNT_W  = 7;
	localparam int PULSE_W = 4;
	localparam int SEL_W   = 5;

	// register indices as selected by the address register
	localparam logic [SEL_W-1:0] R_HTOTAL    = 5'd0;
	localparam logic [SEL_W-1:0] R_HDISP     = 5'd1;
	localparam logic [SEL_W-1:0] R_HSYNC     = 5'd2;
	localparam logic [SEL_W-1:0] R_SYNCW     = 5'd3;
	localparam logic [SEL_W-1:0] R_VTOTAL    = 5'd4;
	localparam logic [SEL_W-1:0] R_VADJ      = 5'd5;
	localparam logic [SEL_W-1:0] R_VDISP     = 5'd6;
	localparam logic [SEL_W-1:0] R_VSYNC     = 5'd7;
	localparam logic [SEL_W-1:0] R_INTERLACE = 5'd8;
	localparam logic [SEL_W-1:0] R_MAXSCAN   = 5'd9;
	localparam logic [SEL_W-1:0] R_CUR_START = 5'd10;
	localparam logic [SEL_W-1:0] R_CUR_END   = 5'd11;
	localparam logic [SEL_W-1:0] R_START_HI  = 5'd12;
	localparam logic [SEL_W-1:0] R_START_LO  = 5'd13;
	localparam logic [SEL_W-1:0] R_CUR_HI    = 5'd14;
	localparam logic [SEL_W-1:0] R_CUR_LO    = 5'd15;
	localparam logic [SEL_W-1:0] R_LPEN_HI   = 5'd16;
	localparam logic [SEL_W-1:0] R_LPEN_LO   = 5'd17;

	// cursor blink modes, bits 6:5 of register 10
	localparam logic [1:0] BLINK_ON  = 2'b00;
	localparam logic [1:0] BLINK_OFF = 2'b01;
	localparam logic [1:0] BLINK_16  = 2'b10;
	localparam logic [1:0] BLINK_32  = 2'b11;

endpackage

`default_nettype wire

/* design/crtc_regs.sv */
// CRT controller host registers

`timescale 1ns/1ps
`default_nettype none

module crtc_regs (
	input  logic       char_clk,
	input  logic       nRESET,
	input  logic       en,
	input  logic       nCS,
	input  logic       RnW,
	input  logic       RS,
	input  logic       LPSTB,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       data_oe,
	crtc_cfg_if.regs   cfg,
	crtc_beam_if.regs  beam
);

	logic [crtc_pkg::SEL_W-1:0] addr_reg;
	logic [crtc_pkg::ADR_W-1:0] lpen_adr;
	logic                       lpstb_q;
	logic                       wr;

	assign wr      = en & ~nCS & ~RnW;
	assign data_oe = en & ~nCS & RnW;

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			addr_reg              <= '0;
			cfg.horz_total        <= '0;
			cfg.horz_display      <= '0;
			cfg.horz_syncpos      <= '0;
			cfg.horz_pulse        <= '0;
			cfg.vert_pulse        <= '0;
			cfg.vert_total        <= '0;
			cfg.vert_fraction     <= '0;
			cfg.vert_display      <= '0;
			cfg.vert_syncpos      <= '0;
			cfg.max_scanline      <= '0;
			cfg.cursor_blink_mode <= '0;
			cfg.cursor_start_row  <= '0;
			cfg.cursor_end_row    <= '0;
			cfg.start_address     <= '0;
			cfg.cursor_adr        <= '0;
		end else if (wr && !RS) begin
			addr_reg <= data_in[crtc_pkg::SEL_W-1:0];
		end else if (wr) begin
			case (addr_reg)
				crtc_pkg::R_HTOTAL:  cfg.horz_total   <= data_in;
				crtc_pkg::R_HDISP:   cfg.horz_display <= data_in;
				crtc_pkg::R_HSYNC:   cfg.horz_syncpos <= data_in;
				crtc_pkg::R_SYNCW:   {cfg.vert_pulse, cfg.horz_pulse} <= data_in;
				crtc_pkg::R_VTOTAL:  cfg.vert_total    <= data_in[crtc_pkg::VCNT_W-1:0];
				crtc_pkg::R_VADJ:    cfg.vert_fraction <= data_in[crtc_pkg::ROW_W-1:0];
				crtc_pkg::R_VDISP:   cfg.vert_display  <= data_in[crtc_pkg::VCNT_W-1:0];
				crtc_pkg::R_VSYNC:   cfg.vert_syncpos  <= data_in[crtc_pkg::VCNT_W-1:0];
				// no interlace support, the write is dropped
				crtc_pkg::R_INTERLACE: ;
				crtc_pkg::R_MAXSCAN: cfg.max_scanline  <= data_in[crtc_pkg::ROW_W-1:0];
				crtc_pkg::R_CUR_START:
					{cfg.cursor_blink_mode, cfg.cursor_start_row} <= data_in[6:0];
				crtc_pkg::R_CUR_END: cfg.cursor_end_row <= data_in[crtc_pkg::ROW_W-1:0];
				crtc_pkg::R_START_HI:
					cfg.start_address[crtc_pkg::ADR_W-1:8] <= data_in[crtc_pkg::ADR_W-9:0];
				crtc_pkg::R_START_LO: cfg.start_address[7:0] <= data_in;
				crtc_pkg::R_CUR_HI:
					cfg.cursor_adr[crtc_pkg::ADR_W-1:8] <= data_in[crtc_pkg::ADR_W-9:0];
				crtc_pkg::R_CUR_LO:  cfg.cursor_adr[7:0] <= data_in;
				default: ;
			endcase
		end
	end

	// light pen, capture on the rising strobe
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			lpstb_q  <= 1'b0;
			lpen_adr <= '0;
		end else begin
			lpstb_q <= LPSTB;
			if (LPSTB && !lpstb_q)
				lpen_adr <= beam.framestore_adr;
		end
	end

	// only cursor and light pen addresses are readable
	always_comb begin
		case (addr_reg)
			crtc_pkg::R_CUR_HI:  data_out = 8'(cfg.cursor_adr[crtc_pkg::ADR_W-1:8]);
			crtc_pkg::R_CUR_LO:  data_out = cfg.cursor_adr[7:0];
			crtc_pkg::R_LPEN_HI: data_out = 8'(lpen_adr[crtc_pkg::ADR_W-1:8]);
			crtc_pkg::R_LPEN_LO: data_out = lpen_adr[7:0];
			default:             data_out = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

/* design/crtc_scan.sv */
// CRT controller address and cursor

`timescale 1ns/1ps
`default_nettype none

module crtc_scan (
	input  logic      char_clk,
	input  logic      nRESET,
	output logic      display_en,
	output logic      cursor,
	crtc_cfg_if.scan  cfg,
	crtc_beam_if.scan beam
);

	logic [crtc_pkg::ADR_W-1:0] row_base;
	logic [4:0]                 field_cnt;
	logic                       row_hit;
	logic                       blink_ok;

	// base of the current character row
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			row_base <= '0;
		end else if (beam.frame_end) begin
			row_base <= cfg.start_address;
		end else if (beam.row_start) begin
			row_base <= row_base + {{(crtc_pkg::ADR_W-crtc_pkg::HCNT_W){1'b0}},
				cfg.horz_display};
		end
	end

	// wraps at 16K
	assign beam.framestore_adr = row_base +
		{{(crtc_pkg::ADR_W-crtc_pkg::HCNT_W){1'b0}}, beam.h_count};

	assign display_en = beam.h_display && beam.v_display;

	// field count drives the blink rate
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			field_cnt <= '0;
		end else if (beam.frame_end) begin
			field_cnt <= field_cnt + 1'b1;
		end
	end

	always_comb begin
		case (cfg.cursor_blink_mode)
			crtc_pkg::BLINK_ON:  blink_ok = 1'b1;
			crtc_pkg::BLINK_OFF: blink_ok = 1'b0;
			crtc_pkg::BLINK_16:  blink_ok = !field_cnt[3];
			crtc_pkg::BLINK_32:  blink_ok = !field_cnt[4];
			default:             blink_ok = 1'b0;
		endcase
	end

	assign row_hit = (beam.scanline_row >= cfg.cursor_start_row) &&
		(beam.scanline_row <= cfg.cursor_end_row);

	assign cursor = display_en && blink_ok && row_hit &&
		(beam.framestore_adr == cfg.cursor_adr);

endmodule

`default_nettype wire

/* design/crtc_top.sv */
// CRT controller top level

`timescale 1ns/1ps
`default_nettype none

module crtc_top (
	input  logic                         char_clk,
	input  logic                         nRESET,
	input  logic                         en,
	input  logic                         nCS,
	input  logic                         RnW,
	input  logic                         RS,
	input  logic                         LPSTB,
	input  logic [7:0]                   data_in,
	output logic [7:0]                   data_out,
	output logic                         data_oe,
	output logic [crtc_pkg::ADR_W-1:0]   framestore_adr,
	output logic [crtc_pkg::ROW_W-1:0]   scanline_row,
	output logic                         display_en,
	output logic                         h_sync,
	output logic                         v_sync,
	output logic                         cursor
);

	crtc_cfg_if  cfg ();
	crtc_beam_if beam ();

	crtc_regs u_regs (
		.char_clk (char_clk),
		.nRESET   (nRESET),
		.en       (en),
		.nCS      (nCS),
		.RnW      (RnW),
		.RS       (RS),
		.LPSTB    (LPSTB),
		.data_in  (data_in),
		.data_out (data_out),
		.data_oe  (data_oe),
		.cfg      (cfg.regs),
		.beam     (beam.regs)
	);

	crtc_horiz u_horiz (
		.char_clk (char_clk),
		.nRESET   (nRESET),
		.h_sync   (h_sync),
		.cfg      (cfg.horiz),
		.beam     (beam.horiz)
	);

	crtc_vert u_vert (
		.char_clk (char_clk),
		.nRESET   (nRESET),
		.v_sync   (v_sync),
		.cfg      (cfg.vert),
		.beam     (beam.vert)
	);

	crtc_scan u_scan (
		.char_clk   (char_clk),
		.nRESET     (nRESET),
		.display_en (display_en),
		.cursor     (cursor),
		.cfg        (cfg.scan),
		.beam       (beam.scan)
	);

	assign framestore_adr = beam.framestore_adr;
	assign scanline_row   = beam.scanline_row;

endmodule

`default_nettype wire

/* design/crtc_vert.sv */
// CRT controller vertical timing

`timescale 1ns/1ps
`default_nettype none

module crtc_vert (
	input  logic      char_clk,
	input  logic      nRESET,
	output logic      v_sync,
	crtc_cfg_if.vert  cfg,
	crtc_beam_if.vert beam
);

	logic [crtc_pkg::ROW_W-1:0]   scanline_row;
	logic [crtc_pkg::VCNT_W-1:0]  v_row;
	logic [crtc_pkg::PULSE_W-1:0] pulse_left;
	logic                         in_adjust;
	logic                         row_last_line;
	logic                         last_row;
	logic                         adjust_last;
	logic                         sync_line;

	assign row_last_line = !in_adjust && (scanline_row == cfg.max_scanline);
	assign last_row      = (v_row == cfg.vert_total);
	// scanline_row restarts at zero when the adjust lines begin
	assign adjust_last   = in_adjust && (scanline_row == cfg.vert_fraction - 1'b1);

	assign beam.scanline_row = scanline_row;
	assign beam.row_start    = beam.scanline_end && row_last_line;
	assign beam.frame_end    = beam.scanline_end &&
		((row_last_line && last_row && cfg.vert_fraction == '0) || adjust_last);
	assign beam.v_display    = !in_adjust && (v_row < cfg.vert_display);

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			scanline_row <= '0;
			v_row        <= '0;
			in_adjust    <= 1'b0;
		end else if (beam.frame_end) begin
			scanline_row <= '0;
			v_row        <= '0;
			in_adjust    <= 1'b0;
		end else if (beam.row_start) begin
			scanline_row <= '0;
			// last row with adjust lines to follow
			if (last_row)
				in_adjust <= 1'b1;
			else
				v_row <= v_row + 1'b1;
		end else if (beam.scanline_end) begin
			scanline_row <= scanline_row + 1'b1;
		end
	end

	// first scanline of the sync row
	assign sync_line = !in_adjust && (v_row == cfg.vert_syncpos) &&
		(scanline_row == '0) && (cfg.vert_pulse != '0);
	assign v_sync    = sync_line || (pulse_left != '0);

	// scanlines of sync still to go after the current one
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			pulse_left <= '0;
		end else if (beam.scanline_end) begin
			if (sync_line)
				pulse_left <= cfg.vert_pulse - 1'b1;
			else if (pulse_left != '0)
				pulse_left <= pulse_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
design/crtc_pkg.sv
design/crtc_if.sv
design/crtc_regs.sv
design/crtc_horiz.sv
design/crtc_vert.sv
design/crtc_scan.sv
design/crtc_top.sv
bench/tb_crtc.sv
